/* design/mips_id_pkg.sv */
`default_nettype none

package mips_id_pkg;

    localparam int WORD_W   = 32;
    localparam int NUM_REGS = 32;

    typedef logic [WORD_W-1:0]           word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;
    typedef logic [7:0]                  aluop_t;
    typedef logic [2:0]                  alusel_t;
    typedef logic [5:0]                  opcode_t;
    typedef logic [5:0]                  funct_t;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_ADDI    = 6'b001000;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;

    // funct field under OP_SPECIAL
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    localparam aluop_t ALUOP_NOP   = 8'b00000000;
    localparam aluop_t ALUOP_AND   = 8'b00100100;
    localparam aluop_t ALUOP_OR    = 8'b00100101;
    localparam aluop_t ALUOP_XOR   = 8'b00100110;
    localparam aluop_t ALUOP_NOR   = 8'b00100111;
    localparam aluop_t ALUOP_SLL   = 8'b01111100;
    localparam aluop_t ALUOP_SRL   = 8'b00000010;
    localparam aluop_t ALUOP_SRA   = 8'b00000011;
    localparam aluop_t ALUOP_ADD   = 8'b00100000;
    localparam aluop_t ALUOP_ADDU  = 8'b00100001;
    localparam aluop_t ALUOP_SUB   = 8'b00100010;
    localparam aluop_t ALUOP_SUBU  = 8'b00100011;
    localparam aluop_t ALUOP_SLT   = 8'b00101010;
    localparam aluop_t ALUOP_SLTU  = 8'b00101011;
    localparam aluop_t ALUOP_ADDI  = 8'b01010101;
    localparam aluop_t ALUOP_ADDIU = 8'b01010110;

    // result group picked in execute
    localparam alusel_t SEL_NOP   = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;
    localparam alusel_t SEL_ARITH = 3'b100;

    typedef struct packed {
        word_t     wdata;
        reg_addr_t wd;
        logic      wreg;
    } fwd_t;

    typedef struct packed {
        aluop_t    aluop;
        alusel_t   alusel;
        logic      wreg;
        reg_addr_t wd;
        logic      reg1_read;
        reg_addr_t reg1_addr;
        logic      reg2_read;
        reg_addr_t reg2_addr;
        word_t     imm;
    } dec_ctrl_t;

    typedef struct packed {
        aluop_t  aluop;
        alusel_t alusel;
        word_t   reg1;
        word_t   reg2;
        logic    wreg;
        reg_addr_t wd;
    } id_ex_t;

endpackage

`default_nettype wire

/* design/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import mips_id_pkg::*;
(
    input  word_t     inst_i,
    output dec_ctrl_t ctrl_o
);

    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t shamt;
    funct_t    funct;
    logic [15:0] imm16;

    aluop_t  sp_aluop;
    alusel_t sp_alusel;
    logic    sp_shamt;   // shift amount comes from the instruction
    aluop_t  i_aluop;
    alusel_t i_alusel;
    word_t   i_imm;

    assign opcode = inst_i[31:26];
    assign rs     = inst_i[25:21];
    assign rt     = inst_i[20:16];
    assign rd     = inst_i[15:11];
    assign shamt  = inst_i[10:6];
    assign funct  = inst_i[5:0];
    assign imm16  = inst_i[15:0];

    // special group keyed on funct
    always_comb begin
        sp_shamt = 1'b0;
        unique case (funct)
            FN_AND:  {sp_aluop, sp_alusel} = {ALUOP_AND, SEL_LOGIC};
            FN_OR:   {sp_aluop, sp_alusel} = {ALUOP_OR, SEL_LOGIC};
            FN_XOR:  {sp_aluop, sp_alusel} = {ALUOP_XOR, SEL_LOGIC};
            FN_NOR:  {sp_aluop, sp_alusel} = {ALUOP_NOR, SEL_LOGIC};
            FN_SLL: begin
                {sp_aluop, sp_alusel} = {ALUOP_SLL, SEL_SHIFT};
                sp_shamt = 1'b1;   // also nop and ssnop
            end
            FN_SRL: begin
                {sp_aluop, sp_alusel} = {ALUOP_SRL, SEL_SHIFT};
                sp_shamt = 1'b1;
            end
            FN_SRA: begin
                {sp_aluop, sp_alusel} = {ALUOP_SRA, SEL_SHIFT};
                sp_shamt = 1'b1;
            end
            FN_SLLV: {sp_aluop, sp_alusel} = {ALUOP_SLL, SEL_SHIFT};
            FN_SRLV: {sp_aluop, sp_alusel} = {ALUOP_SRL, SEL_SHIFT};
            FN_SRAV: {sp_aluop, sp_alusel} = {ALUOP_SRA, SEL_SHIFT};
            FN_ADD:  {sp_aluop, sp_alusel} = {ALUOP_ADD, SEL_ARITH};
            FN_ADDU: {sp_aluop, sp_alusel} = {ALUOP_ADDU, SEL_ARITH};
            FN_SUB:  {sp_aluop, sp_alusel} = {ALUOP_SUB, SEL_ARITH};
            FN_SUBU: {sp_aluop, sp_alusel} = {ALUOP_SUBU, SEL_ARITH};
            FN_SLT:  {sp_aluop, sp_alusel} = {ALUOP_SLT, SEL_ARITH};
            FN_SLTU: {sp_aluop, sp_alusel} = {ALUOP_SLTU, SEL_ARITH};
            default: {sp_aluop, sp_alusel} = {ALUOP_NOP, SEL_NOP};
        endcase
    end

    // immediate group keyed on opcode
    always_comb begin
        i_imm = {{(WORD_W-16){imm16[15]}}, imm16};   // sign-extended unless overridden
        unique case (opcode)
            OP_ANDI: begin
                {i_aluop, i_alusel} = {ALUOP_AND, SEL_LOGIC};
                i_imm = {{(WORD_W-16){1'b0}}, imm16};
            end
            OP_ORI: begin
                {i_aluop, i_alusel} = {ALUOP_OR, SEL_LOGIC};
                i_imm = {{(WORD_W-16){1'b0}}, imm16};
            end
            OP_XORI: begin
                {i_aluop, i_alusel} = {ALUOP_XOR, SEL_LOGIC};
                i_imm = {{(WORD_W-16){1'b0}}, imm16};
            end
            OP_LUI: begin
                // or with rs loads the upper half
                {i_aluop, i_alusel} = {ALUOP_OR, SEL_LOGIC};
                i_imm = {imm16, {(WORD_W-16){1'b0}}};
            end
            OP_ADDI:  {i_aluop, i_alusel} = {ALUOP_ADDI, SEL_ARITH};
            OP_ADDIU: {i_aluop, i_alusel} = {ALUOP_ADDIU, SEL_ARITH};
            OP_SLTI:  {i_aluop, i_alusel} = {ALUOP_SLT, SEL_ARITH};
            OP_SLTIU: {i_aluop, i_alusel} = {ALUOP_SLTU, SEL_ARITH};
            default:  {i_aluop, i_alusel} = {ALUOP_NOP, SEL_NOP};
        endcase
    end

    always_comb begin
        ctrl_o           = '0;   // bubble
        ctrl_o.reg1_addr = rs;
        ctrl_o.reg2_addr = rt;
        if (opcode == OP_SPECIAL) begin
            if (sp_aluop != ALUOP_NOP) begin
                ctrl_o.aluop     = sp_aluop;
                ctrl_o.alusel    = sp_alusel;
                ctrl_o.wreg      = 1'b1;
                ctrl_o.wd        = rd;
                ctrl_o.reg2_read = 1'b1;
                if (sp_shamt) begin
                    ctrl_o.imm = {{(WORD_W-$bits(shamt)){1'b0}}, shamt};
                end else begin
                    ctrl_o.reg1_read = 1'b1;
                end
            end
        end else if (i_aluop != ALUOP_NOP) begin
            ctrl_o.aluop     = i_aluop;
            ctrl_o.alusel    = i_alusel;
            ctrl_o.wreg      = 1'b1;
            ctrl_o.wd        = rt;   // I-type writes rt
            ctrl_o.reg1_read = 1'b1;
            ctrl_o.imm       = i_imm;
        end
    end

    // a kept op never leaves the select at zero
    always_comb begin
        if (inst_i != '0) begin
            assert final ((ctrl_o.alusel == SEL_NOP) == (ctrl_o.aluop == ALUOP_NOP))
            else $error("alusel and aluop disagree on bubble for %h", inst_i);
        end
    end

endmodule

`default_nettype wire

/* design/operand_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_mux
    import mips_id_pkg::*;
(
    input  logic      read_i,
    input  reg_addr_t addr_i,
    input  word_t     rf_data_i,
    input  word_t     imm_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 forwards like any other register
    assign ex_hit  = ex_fwd_i.wreg && (ex_fwd_i.wd == addr_i);
    assign mem_hit = mem_fwd_i.wreg && (mem_fwd_i.wd == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_fwd_i.wdata;   // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_fwd_i.wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

    // forwarding must never override an immediate
    always_comb begin
        if (!read_i) begin
            assert final (operand_o == imm_i)
            else $error("operand differs from immediate with read low");
        end
    end

endmodule

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile
    import mips_id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // read ports with write-through
    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else if (we_i && (waddr_i == raddr1_i)) begin
            rdata1_o = wdata_i;
        end else begin
            rdata1_o = regs[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else if (we_i && (waddr_i == raddr2_i)) begin
            rdata2_o = wdata_i;
        end else begin
            rdata2_o = regs[raddr2_i];
        end
    end

    // r0 stays zero even right after a write to it
    assert property (@(posedge clk) disable iff (rst)
        (raddr1_i == '0) |-> (rdata1_o == '0))
    else $error("read port 1 returned nonzero for r0");

    assert property (@(posedge clk) disable iff (rst)
        (raddr2_i == '0) |-> (rdata2_o == '0))
    else $error("read port 2 returned nonzero for r0");

endmodule

`default_nettype wire

/* design/mips_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_id_stage
    import mips_id_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     inst_i,
    input  fwd_t      ex_fwd_i,
    input  fwd_t      mem_fwd_i,
    input  logic      wb_we_i,
    input  reg_addr_t wb_addr_i,
    input  word_t     wb_data_i,
    output id_ex_t    id_ex_o
);

    dec_ctrl_t ctrl;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    word_t     op1;
    word_t     op2;
    id_ex_t    id_ex_d;

    instr_decoder u_decoder (
        .inst_i (inst_i),
        .ctrl_o (ctrl)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .we_i     (wb_we_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .raddr1_i (ctrl.reg1_addr),
        .raddr2_i (ctrl.reg2_addr),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2)
    );

    // shamt lands on the rs side for shift-by-constant
    operand_mux u_op1 (
        .read_i    (ctrl.reg1_read),
        .addr_i    (ctrl.reg1_addr),
        .rf_data_i (rf_rdata1),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op1)
    );

    operand_mux u_op2 (
        .read_i    (ctrl.reg2_read),
        .addr_i    (ctrl.reg2_addr),
        .rf_data_i (rf_rdata2),
        .imm_i     (ctrl.imm),
        .ex_fwd_i  (ex_fwd_i),
        .mem_fwd_i (mem_fwd_i),
        .operand_o (op2)
    );

    always_comb begin
        id_ex_d.aluop  = ctrl.aluop;
        id_ex_d.alusel = ctrl.alusel;
        id_ex_d.reg1   = op1;
        id_ex_d.reg2   = op2;
        id_ex_d.wreg   = ctrl.wreg;
        id_ex_d.wd     = ctrl.wd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= id_ex_d;   // one cycle into execute
        end
    end

endmodule

`default_nettype wire

/* dv/tb_id_vectors.svh */
// each row holds instruction, ex result, mem result and writeback
// then expected aluop, alusel, wreg, wd, rs read, rt read and immediate
task automatic fill_vectors();
    // register-register
    vectors.push_back(vec_t'{r_type(5'd1, 5'd2, 5'd3, 5'd0, FN_AND), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_AND, SEL_LOGIC, 1'b1, 5'd3, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd5, 5'd6, 5'd4, 5'd0, FN_NOR), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_NOR, SEL_LOGIC, 1'b1, 5'd4, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd8, 5'd9, 5'd7, 5'd0, FN_ADD), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_ADD, SEL_ARITH, 1'b1, 5'd7, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd11, 5'd12, 5'd10, 5'd0, FN_SUBU), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_SUBU, SEL_ARITH, 1'b1, 5'd10, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd14, 5'd15, 5'd13, 5'd0, FN_SLT), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_SLT, SEL_ARITH, 1'b1, 5'd13, 1'b1, 1'b1, 32'h0});
    // zero, sign and upper-half immediates
    vectors.push_back(vec_t'{i_type(OP_ORI, 5'd17, 5'd16, 16'h8a5c), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_OR, SEL_LOGIC, 1'b1, 5'd16, 1'b1, 1'b0, 32'h0000_8a5c});
    vectors.push_back(vec_t'{i_type(OP_ADDI, 5'd19, 5'd18, 16'hfffc), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_ADDI, SEL_ARITH, 1'b1, 5'd18, 1'b1, 1'b0, 32'hffff_fffc});
    vectors.push_back(vec_t'{i_type(OP_LUI, 5'd0, 5'd20, 16'h1234), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_OR, SEL_LOGIC, 1'b1, 5'd20, 1'b1, 1'b0, 32'h1234_0000});
    // shifts
    vectors.push_back(vec_t'{r_type(5'd0, 5'd22, 5'd21, 5'd5, FN_SLL), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_SLL, SEL_SHIFT, 1'b1, 5'd21, 1'b0, 1'b1, 32'd5});
    vectors.push_back(vec_t'{r_type(5'd0, 5'd24, 5'd23, 5'd31, FN_SRL), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_SRL, SEL_SHIFT, 1'b1, 5'd23, 1'b0, 1'b1, 32'd31});
    vectors.push_back(vec_t'{r_type(5'd0, 5'd26, 5'd25, 5'd17, FN_SRA), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_SRA, SEL_SHIFT, 1'b1, 5'd25, 1'b0, 1'b1, 32'd17});
    vectors.push_back(vec_t'{r_type(5'd29, 5'd28, 5'd27, 5'd0, FN_SLLV), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_SLL, SEL_SHIFT, 1'b1, 5'd27, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd1, 5'd31, 5'd30, 5'd0, FN_SRAV), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_SRA, SEL_SHIFT, 1'b1, 5'd30, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{32'h0, NO_FWD, NO_FWD, NO_FWD,
        ALUOP_SLL, SEL_SHIFT, 1'b1, 5'd0, 1'b0, 1'b1, 32'h0});   // nop
    // forwarding with ex over mem, mem alone, wreg low and r0
    vectors.push_back(vec_t'{r_type(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD),
        make_fwd(32'hdead_beef, 5'd1, 1'b1), make_fwd(32'hcafe_f00d, 5'd1, 1'b1), NO_FWD,
        ALUOP_ADD, SEL_ARITH, 1'b1, 5'd3, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd1, 5'd2, 5'd3, 5'd0, FN_ADD),
        make_fwd(32'h1357_9bdf, 5'd5, 1'b1), make_fwd(32'hcafe_f00d, 5'd2, 1'b1), NO_FWD,
        ALUOP_ADD, SEL_ARITH, 1'b1, 5'd3, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd4, 5'd5, 5'd3, 5'd0, FN_AND),
        make_fwd(32'h1111_1111, 5'd4, 1'b0), make_fwd(32'h2222_2222, 5'd5, 1'b0), NO_FWD,
        ALUOP_AND, SEL_LOGIC, 1'b1, 5'd3, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd0, 5'd7, 5'd6, 5'd0, FN_OR),
        make_fwd(32'h0bad_0bad, 5'd0, 1'b1), NO_FWD, NO_FWD,
        ALUOP_OR, SEL_LOGIC, 1'b1, 5'd6, 1'b1, 1'b1, 32'h0});
    // same-cycle writeback followed by a write to r0
    vectors.push_back(vec_t'{r_type(5'd9, 5'd10, 5'd8, 5'd0, FN_ADD), NO_FWD, NO_FWD,
        make_fwd(32'h5a5a_a5a5, 5'd9, 1'b1),
        ALUOP_ADD, SEL_ARITH, 1'b1, 5'd8, 1'b1, 1'b1, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd0, 5'd9, 5'd11, 5'd0, FN_AND), NO_FWD, NO_FWD,
        make_fwd(32'hffff_ffff, 5'd0, 1'b1),
        ALUOP_AND, SEL_LOGIC, 1'b1, 5'd11, 1'b1, 1'b1, 32'h0});
    // unknown opcode then mult, movn and clz
    vectors.push_back(vec_t'{i_type(6'b111111, 5'd1, 5'd2, 16'h1800), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_NOP, SEL_NOP, 1'b0, 5'd0, 1'b0, 1'b0, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd1, 5'd2, 5'd0, 5'd0, 6'b011000), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_NOP, SEL_NOP, 1'b0, 5'd0, 1'b0, 1'b0, 32'h0});
    vectors.push_back(vec_t'{r_type(5'd3, 5'd4, 5'd5, 5'd0, 6'b001011), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_NOP, SEL_NOP, 1'b0, 5'd0, 1'b0, 1'b0, 32'h0});
    vectors.push_back(vec_t'{i_type(6'b011100, 5'd1, 5'd0, 16'h1820), NO_FWD, NO_FWD, NO_FWD,
        ALUOP_NOP, SEL_NOP, 1'b0, 5'd0, 1'b0, 1'b0, 32'h0});
endtask

/* dv/tb_mips_id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_id_stage
    import mips_id_pkg::*;
;

    localparam word_t LCG_SEED = 32'h4c79_1875;
    localparam fwd_t  NO_FWD   = '0;

    typedef struct packed {
        word_t     inst;
        fwd_t      ex;
        fwd_t      mem;
        fwd_t      wb;     // writeback port shaped like a forwarded result
        aluop_t    aluop;
        alusel_t   alusel;
        logic      wreg;
        reg_addr_t wd;
        logic      rd1;    // rs read from registers, else immediate
        logic      rd2;    // rt read from registers, else immediate
        word_t     imm;
    } vec_t;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    word_t     inst = '0;
    fwd_t      ex_fwd = '0;
    fwd_t      mem_fwd = '0;
    logic      wb_we = 1'b0;
    reg_addr_t wb_addr = '0;
    word_t     wb_data = '0;
    id_ex_t    id_ex_o;

    vec_t        vectors [$];
    word_t       mirror [NUM_REGS];
    int unsigned cycles = 0;
    int unsigned limit = 1000;

    mips_id_stage u_mips_id_stage (
        .clk       (clk),
        .rst       (rst),
        .inst_i    (inst),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .wb_we_i   (wb_we),
        .wb_addr_i (wb_addr),
        .wb_data_i (wb_data),
        .id_ex_o   (id_ex_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped by cycle limit");
        end
    end

    function automatic word_t lcg_next(word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                     reg_addr_t shamt, funct_t funct);
        return {OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t i_type(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm16);
        return {op, rs, rt, imm16};
    endfunction

    function automatic fwd_t make_fwd(word_t data, reg_addr_t addr, logic we);
        return '{wdata: data, wd: addr, wreg: we};
    endfunction

    `include "tb_id_vectors.svh"

    // immediate first, then ex, mem and the register file with r0 and write-through
    function automatic word_t expected_operand(logic rd, reg_addr_t addr, vec_t v);
        if (!rd) return v.imm;
        if (v.ex.wreg && v.ex.wd == addr) return v.ex.wdata;
        if (v.mem.wreg && v.mem.wd == addr) return v.mem.wdata;
        if (addr == '0) return '0;
        if (v.wb.wreg && v.wb.wd == addr) return v.wb.wdata;
        return mirror[addr];
    endfunction

    function automatic id_ex_t expected_output(vec_t v);
        id_ex_t e;
        e.aluop  = v.aluop;
        e.alusel = v.alusel;
        e.reg1   = expected_operand(v.rd1, v.inst[25:21], v);
        e.reg2   = expected_operand(v.rd2, v.inst[20:16], v);
        e.wreg   = v.wreg;
        e.wd     = v.wd;
        return e;
    endfunction

    task automatic compare_field(string name, word_t got, word_t exp);
        assert (got === exp)
        else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "output check failed");
        end
    endtask

    task automatic check_output(id_ex_t exp);
        compare_field("aluop", word_t'(id_ex_o.aluop), word_t'(exp.aluop));
        compare_field("alusel", word_t'(id_ex_o.alusel), word_t'(exp.alusel));
        compare_field("reg1", id_ex_o.reg1, exp.reg1);
        compare_field("reg2", id_ex_o.reg2, exp.reg2);
        compare_field("wreg", word_t'(id_ex_o.wreg), word_t'(exp.wreg));
        compare_field("wd", word_t'(id_ex_o.wd), word_t'(exp.wd));
    endtask

    initial begin
        word_t  seed;
        vec_t   v;
        id_ex_t pending;
        foreach (mirror[r]) mirror[r] = '0;
        fill_vectors();
        limit = 4 * ((NUM_REGS - 1) + vectors.size()) + 50;
        seed = LCG_SEED;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_output('0);   // register still cleared
        for (int r = 1; r < NUM_REGS; r++) begin
            seed = lcg_next(seed);
            mirror[r] = seed;
            wb_we = 1'b1;
            wb_addr = reg_addr_t'(r);
            wb_data = seed;
            @(negedge clk);
        end
        for (int i = 0; i < vectors.size(); i++) begin
            v = vectors[i];
            inst = v.inst;
            ex_fwd = v.ex;
            mem_fwd = v.mem;
            wb_we = v.wb.wreg;
            wb_addr = v.wb.wd;
            wb_data = v.wb.wdata;
            pending = expected_output(v);
            if (v.wb.wreg && v.wb.wd != '0) mirror[v.wb.wd] = v.wb.wdata;
            @(negedge clk);
            check_output(pending);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+dv
design/mips_id_pkg.sv
design/instr_decoder.sv
design/operand_mux.sv
design/regfile.sv
design/mips_id_stage.sv
dv/tb_mips_id_stage.sv

/* Bender.yml */
package:
  name: mips_id_stage

sources:
  - design/mips_id_pkg.sv
  - design/instr_decoder.sv
  - design/operand_mux.sv
  - design/regfile.sv
  - design/mips_id_stage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mips_id_stage.sv
